// ==== design/baud_timer.sv ====
module baud_timer import bridge_pkg::*; (
  input  logic clk,
  input  logic i_reset,
  input  logic i_tx_run,
  input  logic i_rx_run,
  output logic o_tx_tick,
  output logic o_rx_tick
);

  logic [$clog2(BAUD_DIV)-1:0] tx_cnt;
  logic [$clog2(BAUD_DIV)-1:0] rx_cnt;

  assign o_tx_tick = i_tx_run & (tx_cnt == '0);
  assign o_rx_tick = i_rx_run & (rx_cnt == '0);

  // TX counts a full bit from the start of the frame
  always_ff @(posedge clk) begin
    if (i_reset || !i_tx_run) begin
      tx_cnt <= $clog2(BAUD_DIV)'(BAUD_DIV - 1);
    end else if (o_tx_tick) begin
      tx_cnt <= $clog2(BAUD_DIV)'(BAUD_DIV - 1);
    end else begin
      tx_cnt <= tx_cnt - 1'b1;
    end
  end

  // RX preset to half a bit so ticks land mid-bit
  always_ff @(posedge clk) begin
    if (i_reset || !i_rx_run) begin
      rx_cnt <= $clog2(BAUD_DIV)'(BAUD_DIV / 2 - 1);
    end else if (o_rx_tick) begin
      rx_cnt <= $clog2(BAUD_DIV)'(BAUD_DIV - 1);
    end else begin
      rx_cnt <= rx_cnt - 1'b1;
    end
  end

endmodule

// ==== design/bridge_pkg.sv ====
package bridge_pkg;

  // ==========================================================================
  // Rates and depths
  // ==========================================================================

  // Clock cycles per UART bit
  localparam int BAUD_DIV = 16;

  // Entries per byte FIFO and the matching pointer width
  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_AW = 3;

  // ==========================================================================
  // State encodings
  // ==========================================================================

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } uart_tx_state_t;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } uart_rx_state_t;

  // ==========================================================================
  // Grouped signals
  // ==========================================================================

  // SPI pins driven by the external master
  typedef struct packed {
    logic sclk;
    logic cs_n;
    logic mosi;
  } spi_pins_t;

  // FIFO fill levels
  typedef struct packed {
    logic empty;
    logic full;
  } fifo_status_t;

endpackage

// ==== design/byte_fifo.sv ====
module byte_fifo import bridge_pkg::*; (
  input  logic         clk,
  input  logic         i_reset,
  input  logic         i_push,
  input  logic [7:0]   i_wdata,
  input  logic         i_pop,
  output logic [7:0]   o_rdata,
  output fifo_status_t o_status
);

  logic [7:0]       mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_AW:0]   count;
  logic             push_ok;
  logic             pop_ok;

  // ==========================================================================
  // Level flags
  // ==========================================================================

  assign o_status.empty = (count == '0);
  assign o_status.full  = (count == (FIFO_AW + 1)'(FIFO_DEPTH));

  // Dropped when full, ignored when empty
  assign push_ok = i_push & ~o_status.full;
  assign pop_ok  = i_pop & ~o_status.empty;

  // ==========================================================================
  // Pointers and occupancy
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (i_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push_ok, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem[wr_ptr] <= i_wdata;
    end
  end

  // First word falls through
  assign o_rdata = mem[rd_ptr];

  // Occupancy stays in range and agrees with the pointer distance
  a_count_matches_ptrs : assert property (
    @(posedge clk) disable iff (i_reset)
      (count <= (FIFO_AW + 1)'(FIFO_DEPTH))
      && (wr_ptr - rd_ptr == count[FIFO_AW-1:0])
  );

endmodule

// ==== design/spi_slave.sv ====
module spi_slave import bridge_pkg::*; (
  input  logic         clk,
  input  logic         i_reset,
  input  spi_pins_t    i_spi,
  output logic         o_miso,
  output logic         o_tx_push,
  output logic [7:0]   o_tx_data,
  output logic         o_rx_pop,
  input  logic [7:0]   i_rx_data,
  input  fifo_status_t i_rx_status
);

  spi_pins_t  spi_meta;
  spi_pins_t  spi_sync;
  logic       sclk_q;
  logic       cs_n_q;
  logic       sclk_rise;
  logic       sclk_fall;
  logic       cs_fall;
  logic       reload;
  logic [2:0] bit_cnt;
  logic       byte_done;
  logic       miso_valid;
  logic [7:0] mosi_sr;
  logic [7:0] miso_sr;

  // ==========================================================================
  // Pin synchronizers and edge detect
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (i_reset) begin
      spi_meta <= '{sclk: 1'b0, cs_n: 1'b1, mosi: 1'b0};
      spi_sync <= '{sclk: 1'b0, cs_n: 1'b1, mosi: 1'b0};
      sclk_q   <= 1'b0;
      cs_n_q   <= 1'b1;
    end else begin
      spi_meta <= i_spi;
      spi_sync <= spi_meta;
      sclk_q   <= spi_sync.sclk;
      cs_n_q   <= spi_sync.cs_n;
    end
  end

  // SCLK edges only count while selected
  assign sclk_rise = spi_sync.sclk & ~sclk_q & ~spi_sync.cs_n;
  assign sclk_fall = ~spi_sync.sclk & sclk_q & ~spi_sync.cs_n;
  assign cs_fall   = ~spi_sync.cs_n & cs_n_q;

  // ==========================================================================
  // MOSI byte assembly
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (i_reset) begin
      bit_cnt   <= '0;
      o_tx_push <= 1'b0;
    end else begin
      o_tx_push <= 1'b0;
      if (spi_sync.cs_n) begin
        bit_cnt <= '0;
      end else if (sclk_rise) begin
        bit_cnt <= bit_cnt + 3'd1;
        // Eighth bit completes the byte
        if (bit_cnt == 3'd7) begin
          o_tx_push <= 1'b1;
        end
      end
    end
  end

  // MSB first
  always_ff @(posedge clk) begin
    if (sclk_rise) begin
      mosi_sr <= {mosi_sr[6:0], spi_sync.mosi};
    end
  end

  assign o_tx_data = mosi_sr;

  // ==========================================================================
  // MISO byte
  // ==========================================================================

  // New byte at select and after each completed byte
  assign reload = cs_fall | (sclk_fall & byte_done);

  always_ff @(posedge clk) begin
    if (i_reset) begin
      miso_sr    <= 8'h00;
      miso_valid <= 1'b0;
      byte_done  <= 1'b0;
      o_rx_pop   <= 1'b0;
    end else begin
      o_rx_pop <= 1'b0;
      if (reload) begin
        miso_sr    <= i_rx_status.empty ? 8'h00 : i_rx_data;
        miso_valid <= ~i_rx_status.empty;
      end else if (sclk_fall) begin
        miso_sr <= {miso_sr[6:0], 1'b0};
      end
      if (spi_sync.cs_n || reload) begin
        byte_done <= 1'b0;
      end else if (sclk_rise && bit_cnt == 3'd7) begin
        byte_done <= 1'b1;
      end
      // Head byte leaves the FIFO once the master starts clocking it out
      if (sclk_rise && bit_cnt == 3'd0 && miso_valid) begin
        o_rx_pop   <= 1'b1;
        miso_valid <= 1'b0;
      end
    end
  end

  assign o_miso = miso_sr[7];

  // Only a byte that is still in the RX FIFO is popped
  a_pop_not_empty : assert property (
    @(posedge clk) disable iff (i_reset) o_rx_pop |-> !i_rx_status.empty
  );

endmodule

// ==== design/spi_uart_bridge.sv ====
module spi_uart_bridge import bridge_pkg::*; (
  input  logic      clk,
  input  logic      i_reset,
  input  spi_pins_t i_spi,
  output logic      o_miso,
  input  logic      i_uart_rx,
  output logic      o_uart_tx,
  output logic      o_frame_error
);

  // SPI to UART path
  logic         tx_push;
  logic [7:0]   tx_wdata;
  logic         tx_pop;
  logic [7:0]   tx_rdata;
  fifo_status_t tx_status;

  // UART to SPI path
  logic         rx_push;
  logic [7:0]   rx_wdata;
  logic         rx_pop;
  logic [7:0]   rx_rdata;
  fifo_status_t rx_status;

  // Bit timing
  logic tx_run;
  logic rx_run;
  logic tx_tick;
  logic rx_tick;

  // ==========================================================================
  // Blocks
  // ==========================================================================

  spi_slave u_spi_slave (
    .clk         (clk),
    .i_reset     (i_reset),
    .i_spi       (i_spi),
    .o_miso      (o_miso),
    .o_tx_push   (tx_push),
    .o_tx_data   (tx_wdata),
    .o_rx_pop    (rx_pop),
    .i_rx_data   (rx_rdata),
    .i_rx_status (rx_status)
  );

  byte_fifo tx_fifo (
    .clk      (clk),
    .i_reset  (i_reset),
    .i_push   (tx_push),
    .i_wdata  (tx_wdata),
    .i_pop    (tx_pop),
    .o_rdata  (tx_rdata),
    .o_status (tx_status)
  );

  byte_fifo rx_fifo (
    .clk      (clk),
    .i_reset  (i_reset),
    .i_push   (rx_push),
    .i_wdata  (rx_wdata),
    .i_pop    (rx_pop),
    .o_rdata  (rx_rdata),
    .o_status (rx_status)
  );

  baud_timer u_baud_timer (
    .clk       (clk),
    .i_reset   (i_reset),
    .i_tx_run  (tx_run),
    .i_rx_run  (rx_run),
    .o_tx_tick (tx_tick),
    .o_rx_tick (rx_tick)
  );

  uart_ctl u_uart_ctl (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_tx_status   (tx_status),
    .i_tx_data     (tx_rdata),
    .o_tx_pop      (tx_pop),
    .o_uart_tx     (o_uart_tx),
    .i_uart_rx     (i_uart_rx),
    .o_rx_push     (rx_push),
    .o_rx_data     (rx_wdata),
    .o_frame_error (o_frame_error),
    .o_tx_run      (tx_run),
    .o_rx_run      (rx_run),
    .i_tx_tick     (tx_tick),
    .i_rx_tick     (rx_tick)
  );

endmodule

// ==== design/uart_ctl.sv ====
module uart_ctl import bridge_pkg::*; (
  input  logic         clk,
  input  logic         i_reset,
  input  fifo_status_t i_tx_status,
  input  logic [7:0]   i_tx_data,
  output logic         o_tx_pop,
  output logic         o_uart_tx,
  input  logic         i_uart_rx,
  output logic         o_rx_push,
  output logic [7:0]   o_rx_data,
  output logic         o_frame_error,
  output logic         o_tx_run,
  output logic         o_rx_run,
  input  logic         i_tx_tick,
  input  logic         i_rx_tick
);

  uart_tx_state_t tx_state;
  logic [7:0]     tx_sr;
  logic [2:0]     tx_bit;

  uart_rx_state_t rx_state;
  logic           rx_meta;
  logic           rx_sync;
  logic           rx_q;
  logic           rx_fall;
  logic [7:0]     rx_sr;
  logic [2:0]     rx_bit;

  // ==========================================================================
  // Transmitter
  // ==========================================================================

  // One byte per frame, taken only from idle
  assign o_tx_pop = (tx_state == TX_IDLE) & ~i_tx_status.empty;
  assign o_tx_run = (tx_state != TX_IDLE);

  always_ff @(posedge clk) begin
    if (i_reset) begin
      tx_state  <= TX_IDLE;
      tx_bit    <= '0;
      o_uart_tx <= 1'b1;
    end else begin
      case (tx_state)
        TX_IDLE: begin
          if (o_tx_pop) begin
            tx_state  <= TX_START;
            o_uart_tx <= 1'b0;
          end
        end
        TX_START: begin
          if (i_tx_tick) begin
            tx_state  <= TX_DATA;
            tx_bit    <= '0;
            o_uart_tx <= tx_sr[0];
          end
        end
        TX_DATA: begin
          if (i_tx_tick) begin
            if (tx_bit == 3'd7) begin
              tx_state  <= TX_STOP;
              o_uart_tx <= 1'b1;
            end else begin
              tx_bit    <= tx_bit + 3'd1;
              o_uart_tx <= tx_sr[0];
            end
          end
        end
        TX_STOP: begin
          if (i_tx_tick) begin
            tx_state <= TX_IDLE;
          end
        end
        default: tx_state <= TX_IDLE;
      endcase
    end
  end

  // LSB first
  always_ff @(posedge clk) begin
    if (o_tx_pop) begin
      tx_sr <= i_tx_data;
    end else if (i_tx_tick && (tx_state == TX_START || tx_state == TX_DATA)) begin
      tx_sr <= {1'b0, tx_sr[7:1]};
    end
  end

  // ==========================================================================
  // Receiver
  // ==========================================================================

  // Line idles high
  always_ff @(posedge clk) begin
    if (i_reset) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_q    <= 1'b1;
    end else begin
      rx_meta <= i_uart_rx;
      rx_sync <= rx_meta;
      rx_q    <= rx_sync;
    end
  end

  assign rx_fall  = rx_q & ~rx_sync;
  assign o_rx_run = (rx_state != RX_IDLE);

  always_ff @(posedge clk) begin
    if (i_reset) begin
      rx_state      <= RX_IDLE;
      rx_bit        <= '0;
      o_rx_push     <= 1'b0;
      o_frame_error <= 1'b0;
    end else begin
      o_rx_push     <= 1'b0;
      o_frame_error <= 1'b0;
      case (rx_state)
        RX_IDLE: begin
          if (rx_fall) begin
            rx_state <= RX_START;
          end
        end
        RX_START: begin
          // Glitch shorter than half a bit is a false start
          if (i_rx_tick) begin
            rx_state <= rx_sync ? RX_IDLE : RX_DATA;
            rx_bit   <= '0;
          end
        end
        RX_DATA: begin
          if (i_rx_tick) begin
            rx_bit <= rx_bit + 3'd1;
            if (rx_bit == 3'd7) begin
              rx_state <= RX_STOP;
            end
          end
        end
        RX_STOP: begin
          if (i_rx_tick) begin
            rx_state      <= RX_IDLE;
            o_rx_push     <= rx_sync;
            o_frame_error <= ~rx_sync;
          end
        end
        default: rx_state <= RX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (i_rx_tick && rx_state == RX_DATA) begin
      rx_sr <= {rx_sync, rx_sr[7:1]};
    end
  end

  assign o_rx_data = rx_sr;

  a_tx_line_high : assert property (
    @(posedge clk) disable iff (i_reset)
      (tx_state == TX_IDLE || tx_state == TX_STOP) |-> o_uart_tx
  );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module testbench_top -o sim_bin
./obj_dir/sim_bin > sim.log
cat sim.log

if grep -qx "sim passed" sim.log; then
  echo "Simulation result: pass"
else
  echo "Simulation result: fail"
  exit 1
fi

// ==== src.f ====
design/bridge_pkg.sv
design/byte_fifo.sv
design/baud_timer.sv
design/spi_slave.sv
design/uart_ctl.sv
design/spi_uart_bridge.sv
testbench/testbench_top.sv

// ==== testbench/testbench_top.sv ====
module testbench_top import bridge_pkg::*; ();

  // ==========================================================================
  // Constants
  // ==========================================================================

  localparam int CLK_PERIOD = 40;
  localparam int SPI_HALF = 4;
  localparam bit [31:0] SEED = 32'he3883aaa;

  // Bytes moved over either interface across all tests
  localparam int NUM_BYTES = 17;
  localparam longint WATCHDOG_LIMIT = (NUM_BYTES + 4) * 10 * BAUD_DIV * CLK_PERIOD * 2;

  logic      clk;
  logic      i_reset;
  spi_pins_t i_spi;
  logic      o_miso;
  logic      i_uart_rx;
  logic      o_uart_tx;
  logic      o_frame_error;

  int value_errors;
  int other_errors;
  int ferr_count = 0;
  logic idle_check;
  logic ferr_window;
  logic frame_busy;

  // Bytes written over SPI, waiting to show up on o_uart_tx
  logic [7:0] tx_expect [$];

  spi_uart_bridge UUT (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_spi         (i_spi),
    .o_miso        (o_miso),
    .i_uart_rx     (i_uart_rx),
    .o_uart_tx     (o_uart_tx),
    .o_frame_error (o_frame_error)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ==========================================================================
  // Helpers
  // ==========================================================================

  function automatic logic [7:0] rand_byte();
    // Zero is what an empty RX FIFO reads back
    return 8'($urandom_range(255, 1));
  endfunction

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    assert (act === exp) else begin
      value_errors++;
      $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic report_counts();
    $display("Error summary: %0d value mismatches, %0d other failures",
             value_errors, other_errors);
  endtask

  // Mode 0, MSB first, one byte per select
  task automatic spi_xfer(input logic [7:0] mosi_byte, output logic [7:0] miso_byte);
    int i;
    tx_expect.push_back(mosi_byte);
    @(negedge clk);
    i_spi.cs_n = 1'b0;
    for (i = 7; i >= 0; i--) begin
      i_spi.mosi = mosi_byte[i];
      repeat (SPI_HALF) @(negedge clk);
      miso_byte[i] = o_miso;
      i_spi.sclk = 1'b1;
      repeat (SPI_HALF) @(negedge clk);
      i_spi.sclk = 1'b0;
    end
    repeat (SPI_HALF) @(negedge clk);
    i_spi.cs_n = 1'b1;
    repeat (SPI_HALF) @(negedge clk);
  endtask

  // 8N1 frame, then one idle bit
  task automatic uart_send(input logic [7:0] data, input logic good_stop);
    int i;
    @(negedge clk);
    i_uart_rx = 1'b0;
    repeat (BAUD_DIV) @(negedge clk);
    for (i = 0; i < 8; i++) begin
      i_uart_rx = data[i];
      repeat (BAUD_DIV) @(negedge clk);
    end
    i_uart_rx = good_stop;
    repeat (BAUD_DIV) @(negedge clk);
    i_uart_rx = 1'b1;
    repeat (BAUD_DIV) @(negedge clk);
  endtask

  // Until every written byte has left o_uart_tx
  task automatic wait_uart_idle();
    while (tx_expect.size() != 0 || frame_busy) begin
      @(negedge clk);
    end
  endtask

  // ==========================================================================
  // UART TX monitor
  // ==========================================================================

  // Every cycle of the frame is checked, so bit widths are checked too
  initial begin : uart_monitor
    logic [9:0] frame;
    logic [7:0] exp_byte;
    int k;
    frame_busy = 1'b0;
    @(negedge i_reset);
    forever begin
      @(negedge clk);
      if (o_uart_tx === 1'b0) begin
        frame_busy = 1'b1;
        if (tx_expect.size() == 0) begin
          other_errors++;
          $display("UART frame at t=%0t with no byte written over SPI", $time);
          repeat (10 * BAUD_DIV - 1) @(negedge clk);
        end else begin
          exp_byte = tx_expect.pop_front();
          frame = {1'b1, exp_byte, 1'b0};
          for (k = 0; k < 10 * BAUD_DIV; k++) begin
            if (k != 0) begin
              @(negedge clk);
            end
            assert (o_uart_tx === frame[k / BAUD_DIV]) else begin
              value_errors++;
              $display("FAIL t=%0t o_uart_tx bit %0d of byte %h expected %b got %b",
                       $time, k / BAUD_DIV, exp_byte, frame[k / BAUD_DIV], o_uart_tx);
            end
          end
        end
        frame_busy = 1'b0;
      end
    end
  end

  always @(negedge clk) begin
    if (!i_reset && o_frame_error) begin
      ferr_count++;
    end
  end

  // ==========================================================================
  // Port assertions
  // ==========================================================================

  a_idle_tx : assert property (@(posedge clk) disable iff (i_reset)
    idle_check |-> o_uart_tx) else begin
    value_errors++;
    $display("FAIL t=%0t o_uart_tx expected 1 got %b", $time, $sampled(o_uart_tx));
  end

  a_idle_ferr : assert property (@(posedge clk) disable iff (i_reset)
    idle_check |-> !o_frame_error) else begin
    value_errors++;
    $display("FAIL t=%0t o_frame_error expected 0 got %b", $time, $sampled(o_frame_error));
  end

  a_idle_miso : assert property (@(posedge clk) disable iff (i_reset)
    idle_check |-> !o_miso) else begin
    value_errors++;
    $display("FAIL t=%0t o_miso expected 0 got %b", $time, $sampled(o_miso));
  end

  a_ferr_window : assert property (@(posedge clk) disable iff (i_reset)
    o_frame_error |-> ferr_window) else begin
    other_errors++;
    $display("Frame error at t=%0t while no bad stop bit was sent", $time);
  end

  a_ferr_pulse : assert property (@(posedge clk) disable iff (i_reset)
    o_frame_error |=> !o_frame_error) else begin
    value_errors++;
    $display("FAIL t=%0t o_frame_error expected 0 got 1", $time);
  end

  initial begin : watchdog
    #(WATCHDOG_LIMIT);
    other_errors++;
    $display("Watchdog expired before the tests finished");
    report_counts();
    $display("sim failed");
    $finish;
  end

  // ==========================================================================
  // Stimulus
  // ==========================================================================

  initial begin : stimulus
    int i;
    int ferr_before;
    logic [7:0] rd;
    logic [7:0] rx_bytes [3];
    value_errors = 0;
    other_errors = 0;
    idle_check = 1'b0;
    ferr_window = 1'b0;
    i_reset = 1'b1;
    i_spi = '{sclk: 1'b0, cs_n: 1'b1, mosi: 1'b0};
    i_uart_rx = 1'b1;
    void'($urandom(SEED));
    repeat (16) @(negedge clk);
    i_reset = 1'b0;

    // Outputs at rest
    idle_check = 1'b1;
    repeat (8) @(negedge clk);
    idle_check = 1'b0;

    // Single bytes, each drained before the next
    for (i = 0; i < 3; i++) begin
      spi_xfer(rand_byte(), rd);
      check_byte("o_miso", 8'h00, rd);
      wait_uart_idle();
    end

    // Burst of 5 back to back
    for (i = 0; i < 5; i++) begin
      spi_xfer(rand_byte(), rd);
      check_byte("o_miso", 8'h00, rd);
    end
    wait_uart_idle();

    // Received bytes come back in order
    for (i = 0; i < 3; i++) begin
      rx_bytes[i] = rand_byte();
      uart_send(rx_bytes[i], 1'b1);
    end
    for (i = 0; i < 3; i++) begin
      spi_xfer(rand_byte(), rd);
      check_byte("o_miso", rx_bytes[i], rd);
    end
    wait_uart_idle();

    // Nothing received
    spi_xfer(rand_byte(), rd);
    check_byte("o_miso", 8'h00, rd);
    wait_uart_idle();

    // Low stop bit
    ferr_before = ferr_count;
    ferr_window = 1'b1;
    uart_send(rand_byte(), 1'b0);
    ferr_window = 1'b0;
    assert (ferr_count - ferr_before == 1) else begin
      value_errors++;
      $display("FAIL t=%0t o_frame_error pulses expected 1 got %0d",
               $time, ferr_count - ferr_before);
    end
    spi_xfer(rand_byte(), rd);
    check_byte("o_miso", 8'h00, rd);
    wait_uart_idle();

    repeat (4) @(negedge clk);
    report_counts();
    if (value_errors == 0 && other_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
